//--- testbench/otp_part_patterns.mem
// One 64-bit hex word per line
// Words 0-3 partition blocks 0 to 3, word 4 XOR mask applied to block 2 before the check
// Word 5 zero-based read number that gets an error, words 6 and 7 uncorrectable and correctable codes
0123456789abcdef
fedcba9876543210
a5a5a5a55a5a5a5a
0f1e2d3c4b5a6978
0000000000010000
0000000000000001
0000000000000002
0000000000000001

//--- compile.f
+incdir+source
source/otp_macro_pkg.sv
source/otp_part_pkg.sv
source/otp_read_arbiter.sv
source/part_init_reader.sv
source/part_cnsty_checker.sv
source/part_buffer_regs.sv
source/part_status_ctrl.sv
source/otp_part_buf.sv
testbench/tb_otp_part_buf.sv

//--- testbench/tb_otp_part_buf.sv
// Testbench for the buffered OTP partition, models the macro and replays the patterns file
`include "otp_part_config.svh"

module tb_otp_part_buf;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT      = 200;
  localparam int DATA_W       = `OTP_NUM_BLOCKS * `OTP_BLOCK_W;
  localparam int PULSE_INIT   = 0;
  localparam int PULSE_CHECK  = 1;
  localparam int PULSE_ESCAL  = 2;

  logic                      clk_i, rst_ni, init_req_i, cnsty_chk_req_i, escalate_en_i;
  logic [1:0]                access_i, access_o;
  logic                      init_done_o, cnsty_chk_ack_o;
  otp_part_pkg::part_err_e   error_o;
  logic [DATA_W-1:0]         data_o, exp_data;
  logic                      otp_req_o, otp_gnt_i, otp_rvalid_i;
  logic [`OTP_ADDR_W-1:0]    otp_addr_o;
  logic [`OTP_BLOCK_W-1:0]   otp_rdata_i;
  otp_macro_pkg::macro_err_e otp_err_i;

  // Patterns file holds blocks 0..3, corruption mask, error read number and error codes
  logic [63:0]             patterns [0:7];
  // Macro model state
  logic [`OTP_BLOCK_W-1:0] otp_mem [`OTP_NUM_BLOCKS];
  int                      err_read, read_cnt, gnt_wait, gnt_idx, n;
  logic [2:0]              err_code;
  logic                    req_seen;
  integer                  seed;

  otp_part_buf u_dut (
    .clk_i, .rst_ni, .init_req_i, .cnsty_chk_req_i, .escalate_en_i, .access_i,
    .init_done_o, .cnsty_chk_ack_o, .error_o, .access_o, .data_o,
    .otp_req_o, .otp_addr_o, .otp_gnt_i, .otp_rvalid_i, .otp_rdata_i, .otp_err_i
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Check and failure reporting
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    $display("Result: FAILED");
    $fatal(1, "Run aborted");
  endtask

  // Block index from the halfword address via byte address minus offset over 8
  function automatic int addr_to_block(input logic [`OTP_ADDR_W-1:0] addr);
    int byte_addr;
    byte_addr = int'(addr) * 2;
    return (byte_addr - `OTP_PART_OFFSET) / 8;
  endfunction

  //////////////////////////////////////////////////
  // OTP macro model
  //////////////////////////////////////////////////

  // Grant after 0 to 2 cycles and rvalid one cycle after the grant
  always @(posedge clk_i) begin
    #2;
    otp_rvalid_i = 1'b0;
    if (!rst_ni) begin
      otp_gnt_i = 1'b0;
      req_seen  = 1'b0;
      read_cnt  = 0;
    end else if (otp_gnt_i) begin
      // Grant was taken at this edge
      otp_gnt_i    = 1'b0;
      otp_rvalid_i = 1'b1;
      otp_rdata_i  = otp_mem[gnt_idx];
      otp_err_i    = (read_cnt == err_read) ? otp_macro_pkg::macro_err_e'(err_code)
                                            : otp_macro_pkg::MACRO_NO_ERR;
      read_cnt++;
    end else if (otp_req_o) begin
      if (!req_seen) begin
        req_seen = 1'b1;
        gnt_wait = $unsigned($random(seed)) % 3;
      end
      if (gnt_wait == 0) begin
        otp_gnt_i = 1'b1;
        req_seen  = 1'b0;
        gnt_idx   = addr_to_block(otp_addr_o);
        if (gnt_idx < 0 || gnt_idx >= `OTP_NUM_BLOCKS) begin
          report_failure("read address lies outside the partition");
        end
      end else begin
        gnt_wait--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic load_memory();
    for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
      otp_mem[i] = patterns[i];
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2;
    rst_ni          = 1'b0;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
    repeat (16) @(posedge clk_i);
    #2 rst_ni = 1'b1;
  endtask

  // One-cycle pulse on a DUT request input
  task automatic pulse_input(input int sel);
    @(posedge clk_i);
    #2;
    case (sel)
      PULSE_INIT:  init_req_i = 1'b1;
      PULSE_CHECK: cnsty_chk_req_i = 1'b1;
      default:     escalate_en_i = 1'b1;
    endcase
    @(posedge clk_i);
    #2;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
  endtask

  task automatic wait_init_done();
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      @(negedge clk_i);
      if (init_done_o) break;
    end
    if (!init_done_o) report_failure("init_done_o did not rise before the timeout");
  endtask

  task automatic wait_error();
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      @(negedge clk_i);
      if (error_o != otp_part_pkg::NO_ERR) break;
    end
    if (error_o == otp_part_pkg::NO_ERR) report_failure("error_o stayed clear until the timeout");
  endtask

  // Optionally flags any macro read while waiting
  task automatic wait_ack(input bit forbid_reads);
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      @(negedge clk_i);
      if (forbid_reads) compare_value("otp_req_o", otp_req_o, 1'b0);
      if (cnsty_chk_ack_o) break;
    end
    if (!cnsty_chk_ack_o) report_failure("no consistency check ack before the timeout");
  endtask

  //////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////

  initial begin
    seed = 32'hffec;
    rst_ni = 1'b0;
    init_req_i = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i = 1'b0;
    access_i = 2'b01;
    otp_gnt_i = 1'b0;
    otp_rvalid_i = 1'b0;
    otp_rdata_i = '0;
    otp_err_i = otp_macro_pkg::MACRO_NO_ERR;
    err_read = -1;
    err_code = '0;
    $readmemh("testbench/otp_part_patterns.mem", patterns);
    for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
      exp_data[i*`OTP_BLOCK_W +: `OTP_BLOCK_W] = patterns[i];
    end
    load_memory();
    apply_reset();

    // Locked and blank before init with contents and locks passing through after
    @(negedge clk_i);
    compare_value("data_o", data_o, '0);
    compare_value("access_o", access_o, 2'b11);
    compare_value("init_done_o", init_done_o, 1'b0);
    pulse_input(PULSE_INIT);
    wait_init_done();
    compare_value("data_o", data_o, exp_data);
    compare_value("access_o", access_o, access_i);
    compare_value("error_o", error_o, otp_part_pkg::NO_ERR);

    // Clean check gives exactly one ack
    pulse_input(PULSE_CHECK);
    wait_ack(1'b0);
    for (n = 0; n < 20; n++) begin
      @(negedge clk_i);
      compare_value("cnsty_chk_ack_o", cnsty_chk_ack_o, 1'b0);
    end
    compare_value("error_o", error_o, otp_part_pkg::NO_ERR);
    compare_value("init_done_o", init_done_o, 1'b1);

    // Corrupted macro word makes the check fail
    otp_mem[2] = otp_mem[2] ^ patterns[4];
    pulse_input(PULSE_CHECK);
    wait_ack(1'b0);
    compare_value("error_o", error_o, otp_part_pkg::CHECK_FAIL_ERR);
    compare_value("init_done_o", init_done_o, 1'b0);
    compare_value("data_o", data_o, '0);
    compare_value("access_o", access_o, 2'b11);

    // Uncorrectable error on the second init read
    err_read = int'(patterns[5]);
    err_code = patterns[6][2:0];
    load_memory();
    apply_reset();
    pulse_input(PULSE_INIT);
    wait_error();
    compare_value("error_o", error_o, err_code);
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk_i);
      compare_value("init_done_o", init_done_o, 1'b0);
    end

    // Init still completes with a correctable error
    err_code = patterns[7][2:0];
    apply_reset();
    pulse_input(PULSE_INIT);
    wait_init_done();
    compare_value("error_o", error_o, err_code);
    compare_value("data_o", data_o, exp_data);

    // Check after escalation is acked without macro reads
    err_read = -1;
    apply_reset();
    pulse_input(PULSE_INIT);
    wait_init_done();
    pulse_input(PULSE_ESCAL);
    wait_error();
    compare_value("error_o", error_o, otp_part_pkg::FSM_STATE_ERR);
    pulse_input(PULSE_CHECK);
    wait_ack(1'b1);
    for (n = 0; n < 10; n++) begin
      @(negedge clk_i);
      compare_value("otp_req_o", otp_req_o, 1'b0);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- source/otp_part_buf.sv
// Buffered OTP partition top level, connects arbiter, requesters, buffer and status control
`include "otp_part_config.svh"

module otp_part_buf (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      init_req_i,
  input  logic                                      cnsty_chk_req_i,
  input  logic                                      escalate_en_i,
  input  logic [1:0]                                access_i,
  output logic                                      init_done_o,
  output logic                                      cnsty_chk_ack_o,
  output otp_part_pkg::part_err_e                   error_o,
  output logic [1:0]                                access_o,
  output logic [`OTP_NUM_BLOCKS*`OTP_BLOCK_W-1:0]   data_o,
  // OTP macro read port
  output logic                                      otp_req_o,
  output logic [`OTP_ADDR_W-1:0]                    otp_addr_o,
  input  logic                                      otp_gnt_i,
  input  logic                                      otp_rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]                   otp_rdata_i,
  input  otp_macro_pkg::macro_err_e                 otp_err_i
);

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  logic                    ini_req, ini_gnt, ini_rvalid, chk_req, chk_gnt, chk_rvalid;
  logic [`OTP_ADDR_W-1:0]  ini_addr, chk_addr;
  logic                    wr_en, ini_done, ini_fault, ini_corr, chk_fault, chk_corr;
  logic [`OTP_BLK_IDX_W-1:0] wr_idx, rd_idx;
  logic [`OTP_BLOCK_W-1:0] wr_data, rd_data;
  otp_part_pkg::part_err_e ini_code, chk_code;
  logic                    parity_err, err_state;
  logic [`OTP_NUM_BLOCKS*`OTP_BLOCK_W-1:0] buf_data;

  otp_read_arbiter u_arb (
    .clk_i, .rst_ni,
    .init_req_i(ini_req), .init_addr_i(ini_addr), .init_gnt_o(ini_gnt),
    .init_rvalid_o(ini_rvalid),
    .chk_req_i(chk_req), .chk_addr_i(chk_addr), .chk_gnt_o(chk_gnt), .chk_rvalid_o(chk_rvalid),
    .otp_req_o, .otp_addr_o, .otp_gnt_i, .otp_rvalid_i
  );

  part_init_reader u_reader (
    .clk_i, .rst_ni, .start_i(init_req_i), .err_state_i(err_state),
    .req_o(ini_req), .addr_o(ini_addr), .gnt_i(ini_gnt), .rvalid_i(ini_rvalid),
    .rdata_i(otp_rdata_i), .rerr_i(otp_err_i),
    .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data),
    .done_o(ini_done), .fault_o(ini_fault), .fault_code_o(ini_code), .corr_o(ini_corr)
  );

  // Check may only start once the partition is initialized
  part_cnsty_checker u_checker (
    .clk_i, .rst_ni, .chk_req_i(cnsty_chk_req_i), .ready_i(init_done_o),
    .err_state_i(err_state),
    .req_o(chk_req), .addr_o(chk_addr), .gnt_i(chk_gnt), .rvalid_i(chk_rvalid),
    .rdata_i(otp_rdata_i), .rerr_i(otp_err_i), .rd_idx_o(rd_idx), .rd_data_i(rd_data),
    .ack_o(cnsty_chk_ack_o), .fault_o(chk_fault), .fault_code_o(chk_code), .corr_o(chk_corr)
  );

  part_buffer_regs u_buffer (
    .clk_i, .rst_ni, .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data),
    .rd_idx_i(rd_idx), .rd_data_o(rd_data), .data_o(buf_data), .parity_err_o(parity_err)
  );

  // Requesters never fault in the same cycle, so a plain merge will do
  part_status_ctrl u_status (
    .clk_i, .rst_ni, .init_done_i(ini_done), .fault_i(ini_fault || chk_fault),
    .fault_code_i(ini_fault ? ini_code : chk_code), .corr_i(ini_corr || chk_corr),
    .parity_err_i(parity_err), .escalate_i(escalate_en_i), .access_i, .data_i(buf_data),
    .err_state_o(err_state), .init_done_o, .error_o, .access_o, .data_o
  );

endmodule

//--- source/part_status_ctrl.sv
// Error code, terminal error state, init-done flag, output gating and software locks
`include "otp_part_config.svh"

module part_status_ctrl (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      init_done_i,
  input  logic                                      fault_i,
  input  otp_part_pkg::part_err_e                   fault_code_i,
  input  logic                                      corr_i,
  input  logic                                      parity_err_i,
  input  logic                                      escalate_i,
  // Bit 1 write lock, bit 0 read lock
  input  logic [1:0]                                access_i,
  input  logic [`OTP_NUM_BLOCKS*`OTP_BLOCK_W-1:0]   data_i,
  output logic                                      err_state_o,
  output logic                                      init_done_o,
  output otp_part_pkg::part_err_e                   error_o,
  output logic [1:0]                                access_o,
  output logic [`OTP_NUM_BLOCKS*`OTP_BLOCK_W-1:0]   data_o
);

  otp_part_pkg::part_err_e error_q, fatal_code;
  logic                    err_state_q, init_done_q, fatal;

  assign fatal = fault_i || parity_err_i || escalate_i;

  // Requester fault first, then parity, then escalation
  always_comb begin
    if (fault_i) fatal_code = fault_code_i;
    else if (parity_err_i) fatal_code = otp_part_pkg::CHECK_FAIL_ERR;
    else fatal_code = otp_part_pkg::FSM_STATE_ERR;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q     <= otp_part_pkg::NO_ERR;
      err_state_q <= 1'b0;
      init_done_q <= 1'b0;
    end else begin
      // First fatal code sticks, a correctable code may be overwritten
      if (fatal && !err_state_q) begin
        error_q <= fatal_code;
      end else if (corr_i && error_q == otp_part_pkg::NO_ERR) begin
        error_q <= otp_part_pkg::MACRO_ECC_CORR_ERR;
      end
      if (fatal) err_state_q <= 1'b1;
      // Error state takes the partition offline for good
      if (fatal || err_state_q) init_done_q <= 1'b0;
      else if (init_done_i) init_done_q <= 1'b1;
    end
  end

  assign err_state_o = err_state_q;
  assign init_done_o = init_done_q;
  assign error_o     = error_q;
  assign data_o      = init_done_q ? data_i : '0;
  // Uninitialized partition is fully locked
  assign access_o    = access_i | {2{~init_done_q}};

  err_state_locks_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) err_state_q |-> (&access_o)
  );

endmodule

//--- source/part_buffer_regs.sv
// Block-addressed partition buffer with one parity bit per block and a parity error flag
`include "otp_part_config.svh"

module part_buffer_regs (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Write port, from the init reader
  input  logic                                      wr_en_i,
  input  logic [`OTP_BLK_IDX_W-1:0]                 wr_idx_i,
  input  logic [`OTP_BLOCK_W-1:0]                   wr_data_i,
  // Read port, for the consistency checker
  input  logic [`OTP_BLK_IDX_W-1:0]                 rd_idx_i,
  output logic [`OTP_BLOCK_W-1:0]                   rd_data_o,
  // Whole partition, block 0 in the low bits
  output logic [`OTP_NUM_BLOCKS*`OTP_BLOCK_W-1:0]   data_o,
  output logic                                      parity_err_o
);

  logic [`OTP_BLOCK_W-1:0]    blk_q [`OTP_NUM_BLOCKS];
  logic [`OTP_NUM_BLOCKS-1:0] par_q;

  // Even parity, so all zeros after reset is consistent
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
        blk_q[i] <= '0;
      end
      par_q <= '0;
    end else if (wr_en_i) begin
      blk_q[wr_idx_i] <= wr_data_i;
      par_q[wr_idx_i] <= ^wr_data_i;
    end
  end

  assign rd_data_o = blk_q[rd_idx_i];

  // Flatten and check every stored block
  always_comb begin
    parity_err_o = 1'b0;
    for (int i = 0; i < `OTP_NUM_BLOCKS; i++) begin
      data_o[i*`OTP_BLOCK_W +: `OTP_BLOCK_W] = blk_q[i];
      if ((^blk_q[i]) != par_q[i]) begin
        parity_err_o = 1'b1;
      end
    end
  end

endmodule

//--- source/part_cnsty_checker.sv
// Re-reads the partition on request and compares each block with the buffered copy
`include "otp_part_config.svh"

module part_cnsty_checker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          chk_req_i,
  input  logic                          ready_i,
  input  logic                          err_state_i,
  // Read port toward the arbiter
  output logic                          req_o,
  output logic [`OTP_ADDR_W-1:0]        addr_o,
  input  logic                          gnt_i,
  input  logic                          rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]       rdata_i,
  input  otp_macro_pkg::macro_err_e     rerr_i,
  // Buffer read port
  output logic [`OTP_BLK_IDX_W-1:0]     rd_idx_o,
  input  logic [`OTP_BLOCK_W-1:0]       rd_data_i,
  // Status reporting
  output logic                          ack_o,
  output logic                          fault_o,
  output otp_part_pkg::part_err_e       fault_code_o,
  output logic                          corr_o
);

  typedef enum logic [1:0] {C_IDLE, C_REQ, C_WAIT} chk_state_e;

  chk_state_e                 state_q, state_d;
  logic [`OTP_BLK_IDX_W-1:0]  cnt_q;
  logic                       ack_q, ack_d;
  logic                       rsp, fatal, mismatch, last_blk;

  assign rsp      = (state_q == C_WAIT) && rvalid_i;
  assign fatal    = !(rerr_i inside {otp_macro_pkg::MACRO_NO_ERR, otp_macro_pkg::MACRO_ECC_CORR});
  // Compare against the block at the current index
  assign mismatch = (rdata_i != rd_data_i);
  assign last_blk = (cnt_q == `OTP_BLK_IDX_W'(`OTP_NUM_BLOCKS - 1));

  assign req_o    = (state_q == C_REQ);
  assign addr_o   = `OTP_BLK_ADDR(cnt_q);
  assign rd_idx_o = cnt_q;

  // Macro fault takes precedence over the compare result
  assign fault_o      = rsp && (fatal || mismatch);
  assign fault_code_o = fatal ? otp_part_pkg::part_err_e'(rerr_i) : otp_part_pkg::CHECK_FAIL_ERR;
  assign corr_o       = rsp && (rerr_i == otp_macro_pkg::MACRO_ECC_CORR);

  // Ack sources
  // end of a check, a failing block, a request in error state, an aborted check
  assign ack_d = (rsp && (fault_o || last_blk)) ||
                 (err_state_i && (chk_req_i || state_q != C_IDLE));
  assign ack_o = ack_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      C_IDLE: if (chk_req_i && ready_i && !err_state_i) state_d = C_REQ;
      C_REQ:  if (gnt_i) state_d = C_WAIT;
      C_WAIT: begin
        if (rvalid_i) begin
          state_d = (fault_o || last_blk) ? C_IDLE : C_REQ;
        end
      end
      default: state_d = C_IDLE;
    endcase
    // No reads once the partition is in error
    if (err_state_i) state_d = C_IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= C_IDLE;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
      // Every check starts from block 0
      if (state_q == C_IDLE) begin
        cnt_q <= '0;
      end else if (rsp && !fault_o && !last_blk) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Each request sees a single ack pulse
  ack_single_pulse_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) ack_o |=> !ack_o
  );

endmodule

//--- source/part_init_reader.sv
// Sequences the initial readout of every partition block into the buffer registers
`include "otp_part_config.svh"

module part_init_reader (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          err_state_i,
  // Read port toward the arbiter
  output logic                          req_o,
  output logic [`OTP_ADDR_W-1:0]        addr_o,
  input  logic                          gnt_i,
  input  logic                          rvalid_i,
  input  logic [`OTP_BLOCK_W-1:0]       rdata_i,
  input  otp_macro_pkg::macro_err_e     rerr_i,
  // Buffer write port
  output logic                          wr_en_o,
  output logic [`OTP_BLK_IDX_W-1:0]     wr_idx_o,
  output logic [`OTP_BLOCK_W-1:0]       wr_data_o,
  // Status reporting
  output logic                          done_o,
  output logic                          fault_o,
  output otp_part_pkg::part_err_e       fault_code_o,
  output logic                          corr_o
);

  // Halt is terminal, whether finished or stopped by an error
  typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_HALT} rd_state_e;

  rd_state_e                  state_q, state_d;
  logic [`OTP_BLK_IDX_W-1:0]  cnt_q;
  logic                       rsp, rsp_ok, last_blk;

  assign rsp      = (state_q == R_WAIT) && rvalid_i;
  assign rsp_ok   = rerr_i inside {otp_macro_pkg::MACRO_NO_ERR, otp_macro_pkg::MACRO_ECC_CORR};
  assign last_blk = (cnt_q == `OTP_BLK_IDX_W'(`OTP_NUM_BLOCKS - 1));

  assign req_o  = (state_q == R_REQ);
  assign addr_o = `OTP_BLK_ADDR(cnt_q);

  // Buffer is written in the rvalid cycle
  assign wr_en_o   = rsp && rsp_ok;
  assign wr_idx_o  = cnt_q;
  assign wr_data_o = rdata_i;

  assign done_o       = rsp && rsp_ok && last_blk;
  assign fault_o      = rsp && !rsp_ok;
  assign fault_code_o = otp_part_pkg::part_err_e'(rerr_i);
  assign corr_o       = rsp && (rerr_i == otp_macro_pkg::MACRO_ECC_CORR);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      R_IDLE: if (start_i) state_d = R_REQ;
      R_REQ:  if (gnt_i) state_d = R_WAIT;
      R_WAIT: begin
        if (rvalid_i) begin
          // Stop after the last block or a fatal response
          state_d = (fault_o || last_blk) ? R_HALT : R_REQ;
        end
      end
      R_HALT: state_d = R_HALT;
    endcase
    if (err_state_i) state_d = R_HALT;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= R_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (wr_en_o && !last_blk) cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

//--- source/otp_read_arbiter.sv
// Fixed-priority arbiter sharing the single OTP read port between init reader and checker
`include "otp_part_config.svh"

module otp_read_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Init reader side
  input  logic                   init_req_i,
  input  logic [`OTP_ADDR_W-1:0] init_addr_i,
  output logic                   init_gnt_o,
  output logic                   init_rvalid_o,
  // Consistency checker side
  input  logic                   chk_req_i,
  input  logic [`OTP_ADDR_W-1:0] chk_addr_i,
  output logic                   chk_gnt_o,
  output logic                   chk_rvalid_o,
  // Macro side
  output logic                   otp_req_o,
  output logic [`OTP_ADDR_W-1:0] otp_addr_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i
);

  logic                    busy_q;
  otp_part_pkg::requester_e owner_q;
  otp_part_pkg::requester_e sel;

  // Init always wins
  assign sel = init_req_i ? otp_part_pkg::REQ_INIT : otp_part_pkg::REQ_CHECK;

  // Nothing new goes out while a read is outstanding
  assign otp_req_o  = !busy_q && (init_req_i || chk_req_i);
  assign otp_addr_o = (sel == otp_part_pkg::REQ_INIT) ? init_addr_i : chk_addr_i;

  // Grant passes through in the same cycle
  assign init_gnt_o = otp_req_o && otp_gnt_i && (sel == otp_part_pkg::REQ_INIT);
  assign chk_gnt_o  = otp_req_o && otp_gnt_i && (sel == otp_part_pkg::REQ_CHECK);

  // Response only to the latched owner
  assign init_rvalid_o = otp_rvalid_i && busy_q && (owner_q == otp_part_pkg::REQ_INIT);
  assign chk_rvalid_o  = otp_rvalid_i && busy_q && (owner_q == otp_part_pkg::REQ_CHECK);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= otp_part_pkg::REQ_INIT;
    end else if (otp_req_o && otp_gnt_i) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
    end else if (otp_rvalid_i) begin
      // Owner's rvalid releases the port
      busy_q  <= 1'b0;
    end
  end

  // Macro must not answer a read that was never granted
  rvalid_needs_grant_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) otp_rvalid_i |-> busy_q
  );

endmodule

//--- source/otp_part_pkg.sv
// Types describing the partition itself, referenced by scoped name
package otp_part_pkg;

  //////////////////////////////////////////////////
  // Partition error code
  //////////////////////////////////////////////////

  // Lower codes mirror the macro response so a cast carries them over
  // Upper codes are raised inside the partition
  typedef enum logic [2:0] {
    NO_ERR                = 3'h0,
    MACRO_ECC_CORR_ERR    = 3'h1,
    MACRO_ECC_UNCORR_ERR  = 3'h2,
    MACRO_WRITE_BLANK_ERR = 3'h3,
    CHECK_FAIL_ERR        = 3'h4,
    FSM_STATE_ERR         = 3'h5
  } part_err_e;

  //////////////////////////////////////////////////
  // Read port requesters
  //////////////////////////////////////////////////

  // Index order is also the arbitration priority
  typedef enum logic {
    REQ_INIT  = 1'b0,
    REQ_CHECK = 1'b1
  } requester_e;

endpackage

//--- source/otp_macro_pkg.sv
// Types on the OTP macro side of the partition, referenced by scoped name
package otp_macro_pkg;

  //////////////////////////////////////////////////
  // Macro response
  //////////////////////////////////////////////////

  // Error code returned with every rvalid
  // Codes are shared with the partition error type
  typedef enum logic [2:0] {
    MACRO_NO_ERR      = 3'h0,
    MACRO_ECC_CORR    = 3'h1,
    MACRO_ECC_UNCORR  = 3'h2,
    MACRO_WRITE_BLANK = 3'h3
  } macro_err_e;

endpackage

//--- source/otp_part_config.svh
// Partition geometry and address rules, included by the RTL and the testbench
`ifndef OTP_PART_CONFIG_SVH
`define OTP_PART_CONFIG_SVH

// One buffered block and the number of blocks in the partition
`define OTP_BLOCK_W     64
`define OTP_NUM_BLOCKS  4
`define OTP_BLK_IDX_W   2

// Byte offset of the partition inside OTP
`define OTP_PART_OFFSET 'h40

// Halfword address toward the macro, byte address is one bit wider
`define OTP_ADDR_W      10
`define OTP_BYTE_ADDR_W 11

// Byte address of a block is offset plus index times 8
`define OTP_BLK_BYTE_ADDR(idx) (`OTP_BYTE_ADDR_W'(`OTP_PART_OFFSET) + (`OTP_BYTE_ADDR_W'(idx) << 3))
// Macro works on 16 bit words
`define OTP_BLK_ADDR(idx) (`OTP_ADDR_W'(`OTP_BLK_BYTE_ADDR(idx) >> 1))

`endif
